// ==== dv/tb_checker.sv ====
// =========================================================================
// Reference model and report checks
// =========================================================================

`timescale 1ns/1ns

module tb_checker #(
  parameter int COUNT_W = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  rvfi_valid,
  input  logic [1:0]            rvfi_mode,
  input  logic [31:0]           rvfi_insn,
  input  logic                  rvfi_trap,
  input  logic [5:0]            rvfi_cause,
  input  logic                  rvfi_intr,
  input  logic [31:0]           rvfi_mstatus,
  input  logic                  viol_valid,
  input  insn_pkg::viol_code_e  viol_code,
  input  logic [COUNT_W-1:0]    viol_count,
  output priv_pkg::priv_mode_e  model_mode,
  output int                    outstanding,
  output int                    value_errors,
  output int                    wait_errors
);

  bit                   exp_valid_q[$];
  insn_pkg::viol_code_e exp_code_q[$];
  priv_pkg::priv_mode_e mode_q = priv_pkg::MODE_M;
  logic [COUNT_W-1:0]   count_q = '0;
  int                   pending_n = 0;
  int                   err_n = 0;
  int                   wait_err_n = 0;

  assign model_mode   = mode_q;
  assign outstanding  = pending_n;
  assign value_errors = err_n;
  assign wait_errors  = wait_err_n;

  // expected code of the retirement on the trace right now
  function automatic insn_pkg::viol_code_e expect_code();
    logic       user;
    logic       sys;
    logic [1:0] mpp;
    logic       priv_insn;
    logic       ill_trap;
    user     = (rvfi_mode == 2'b00);
    sys      = (rvfi_insn[6:0] == 7'b1110011);
    mpp      = rvfi_mstatus[12:11];
    ill_trap = rvfi_trap && ((rvfi_cause == 6'd2) || (rvfi_cause == 6'd1));
    priv_insn = (rvfi_insn == insn_pkg::URET_IDATA) || (user && (
      (rvfi_insn == insn_pkg::MRET_IDATA) ||
      ((rvfi_insn == insn_pkg::WFI_IDATA) && rvfi_mstatus[21]) ||
      (sys && (rvfi_insn[14:12] == 3'b000) &&
       ((rvfi_insn[31:26] == 6'b110011) || (rvfi_insn[31:26] == 6'b100011))) ||
      (sys && (rvfi_insn[14:12] != 3'b000) && (rvfi_insn[29:28] != 2'b00))));
    if ((rvfi_mode == 2'b01) || (rvfi_mode == 2'b10)) begin
      return insn_pkg::VIOL_BAD_MODE;
    end
    if ((rvfi_mode != mode_q) && !rvfi_intr) begin
      return insn_pkg::VIOL_NEXT_MODE;
    end
    if (priv_insn && !ill_trap) begin
      return insn_pkg::VIOL_NOT_ILLEGAL;
    end
    if (user && (rvfi_insn == insn_pkg::ECALL_IDATA) &&
        !(rvfi_trap && ((rvfi_cause == 6'd8) || (rvfi_cause == 6'd1)))) begin
      return insn_pkg::VIOL_WRONG_CAUSE;
    end
    if (user && (rvfi_insn == insn_pkg::EBREAK_IDATA) &&
        !(rvfi_trap && ((rvfi_cause == 6'd3) || (rvfi_cause == 6'd1)))) begin
      return insn_pkg::VIOL_WRONG_CAUSE;
    end
    if ((mpp == 2'b01) || (mpp == 2'b10) || (user && rvfi_mstatus[17])) begin
      return insn_pkg::VIOL_BAD_MSTATUS;
    end
    return insn_pkg::VIOL_NONE;
  endfunction

  function automatic priv_pkg::priv_mode_e next_mode();
    if (rvfi_trap) begin
      return priv_pkg::MODE_M;
    end
    if ((rvfi_insn == insn_pkg::MRET_IDATA) && (rvfi_mode == 2'b11)) begin
      return (rvfi_mstatus[12:11] == 2'b00) ? priv_pkg::MODE_U : priv_pkg::MODE_M;
    end
    if (rvfi_mode == 2'b00) begin
      return priv_pkg::MODE_U;
    end
    if (rvfi_mode == 2'b11) begin
      return priv_pkg::MODE_M;
    end
    return mode_q;
  endfunction

  task automatic check_report(input bit exp_valid, input insn_pkg::viol_code_e exp_code);
    if (viol_valid !== exp_valid) begin
      err_n++;
      $display("[ERROR] %0t ns: viol_valid is %b, model expects %b",
               $time, viol_valid, exp_valid);
    end else if (exp_valid && (viol_code !== exp_code)) begin
      err_n++;
      $display("[ERROR] %0t ns: viol_code is %0d, model expects %s",
               $time, viol_code, exp_code.name());
    end
    if (viol_count !== count_q) begin
      err_n++;
      $display("[ERROR] %0t ns: viol_count is %0d, model expects %0d",
               $time, viol_count, count_q);
    end
  endtask

  // inputs and registered outputs are both settled at the falling edge
  always @(negedge clk_i) begin
    bit                   exp_valid;
    insn_pkg::viol_code_e exp_code;
    if (!rst_n) begin
      mode_q    = priv_pkg::MODE_M;
      count_q   = '0;
      pending_n = 0;
      exp_valid_q.delete();
      exp_code_q.delete();
    end else begin
      exp_valid = 1'b0;
      exp_code  = insn_pkg::VIOL_NONE;
      if (exp_valid_q.size() != 0) begin
        exp_valid = exp_valid_q.pop_front();
        exp_code  = exp_code_q.pop_front();
      end
      if (exp_valid) begin
        pending_n--;
        if (count_q != {COUNT_W{1'b1}}) begin
          count_q = count_q + COUNT_W'(1);
        end
      end
      check_report(exp_valid, exp_code);
      exp_code = insn_pkg::VIOL_NONE;
      if (rvfi_valid) begin
        exp_code = expect_code();
        mode_q   = next_mode();
      end
      exp_valid_q.push_back(exp_code != insn_pkg::VIOL_NONE);
      exp_code_q.push_back(exp_code);
      if (exp_code != insn_pkg::VIOL_NONE) begin
        pending_n++;
      end
    end
  end

  initial begin
    int n;
    n = 0;
    while ((rst_n !== 1'b1) && (n < 40)) begin
      @(negedge clk_i);
      n++;
    end
    if (rst_n !== 1'b1) begin
      wait_err_n++;
      $display("reset was not released within 40 cycles");
    end
  end

endmodule

// ==== dv/tb_top.sv ====
// =========================================================================
// Privilege monitor testbench
// =========================================================================

`timescale 1ns/1ns

module tb_top;

  localparam int COUNT_W       = 8;
  localparam int LEGAL_CYCLES  = 400;
  localparam int RANDOM_CYCLES = 3000;

  logic                 clk_i;
  logic                 rst_n;
  logic                 rvfi_valid;
  logic [1:0]           rvfi_mode;
  logic [31:0]          rvfi_insn;
  logic                 rvfi_trap;
  logic [5:0]           rvfi_cause;
  logic                 rvfi_intr;
  logic [31:0]          rvfi_mstatus;
  logic                 viol_valid;
  insn_pkg::viol_code_e viol_code;
  logic [COUNT_W-1:0]   viol_count;
  priv_pkg::priv_mode_e model_mode;
  int                   outstanding;
  int                   value_errors;
  int                   wait_errors;
  int                   drain_errors;
  int                   seed = 35269;

  always #20 clk_i = ~clk_i;

  umode_monitor #(.COUNT_W(COUNT_W)) dut0 (
    .clk_i(clk_i), .rst_n(rst_n), .rvfi_valid(rvfi_valid), .rvfi_mode(rvfi_mode),
    .rvfi_insn(rvfi_insn), .rvfi_trap(rvfi_trap), .rvfi_cause(rvfi_cause),
    .rvfi_intr(rvfi_intr), .rvfi_mstatus(rvfi_mstatus), .viol_valid(viol_valid),
    .viol_code(viol_code), .viol_count(viol_count)
  );

  tb_checker #(.COUNT_W(COUNT_W)) u_checker (
    .clk_i(clk_i), .rst_n(rst_n), .rvfi_valid(rvfi_valid), .rvfi_mode(rvfi_mode),
    .rvfi_insn(rvfi_insn), .rvfi_trap(rvfi_trap), .rvfi_cause(rvfi_cause),
    .rvfi_intr(rvfi_intr), .rvfi_mstatus(rvfi_mstatus), .viol_valid(viol_valid),
    .viol_code(viol_code), .viol_count(viol_count), .model_mode(model_mode),
    .outstanding(outstanding), .value_errors(value_errors), .wait_errors(wait_errors)
  );

  function automatic int rnd(input int n);
    int r;
    r = $random(seed);
    return int'($unsigned(r) % n);
  endfunction

  task automatic drive_idle();
    rvfi_valid   = 1'b0;
    rvfi_mode    = 2'b11;
    rvfi_insn    = 32'h0;
    rvfi_trap    = 1'b0;
    rvfi_cause   = 6'd0;
    rvfi_intr    = 1'b0;
    rvfi_mstatus = 32'h0;
  endtask

  // legal only keeps mode, mstatus and traps consistent with the rules
  task automatic drive_retire(input bit legal);
    logic [1:0]  mode;
    logic [31:0] insn;
    logic [31:0] mstatus;
    logic        user;
    logic        must_ill;
    logic        trap;
    logic [5:0]  cause;
    mode = model_mode;
    if (!legal && (rnd(100) >= 85)) begin
      mode = (rnd(3) == 0) ? 2'(1 + rnd(2)) : ~mode;
    end
    user    = (mode == 2'b00);
    mstatus = $random(seed);
    mstatus[priv_pkg::MPP_POS +: 2] = (rnd(2) == 0) ? 2'b00 : 2'b11;
    if (!legal && (rnd(10) == 0)) begin
      mstatus[priv_pkg::MPP_POS +: 2] = 2'(rnd(4));
    end
    if (user) begin
      mstatus[priv_pkg::MPRV_POS] = !legal && (rnd(8) == 0);
    end
    insn     = $random(seed);
    must_ill = 1'b0;
    case (rnd(16))
      0, 1: begin
        insn     = insn_pkg::MRET_IDATA;
        must_ill = user;
      end
      2: begin
        insn     = insn_pkg::WFI_IDATA;
        must_ill = user && mstatus[priv_pkg::TW_POS];
      end
      3: begin
        insn     = insn_pkg::URET_IDATA;
        must_ill = 1'b1;
      end
      4: insn = insn_pkg::ECALL_IDATA;
      5: insn = insn_pkg::EBREAK_IDATA;
      6: begin
        // custom SYSTEM, rs1 and rd stay random
        insn[31:26] = (rnd(2) == 0) ? 6'b110011 : 6'b100011;
        insn[14:12] = 3'b000;
        insn[6:0]   = 7'b1110011;
        must_ill    = user;
      end
      7, 8: begin
        insn[6:0]   = 7'b1110011;
        insn[14:12] = 3'(1 + rnd(7));
        if (rnd(2) == 0) begin
          insn[29:28] = 2'b00;
        end
        must_ill = user && (insn[29:28] != 2'b00);
      end
      default: begin
        if (legal) begin
          insn[6:0] = 7'b0110011;
        end
      end
    endcase
    trap  = (rnd(10) == 0);
    cause = insn_pkg::EXC_INSN_FAULT;
    if (must_ill) begin
      trap  = 1'b1;
      cause = (rnd(4) == 0) ? insn_pkg::EXC_INSN_FAULT : insn_pkg::EXC_ILLEGAL;
    end else if (insn == insn_pkg::ECALL_IDATA) begin
      trap  = 1'b1;
      cause = user ? insn_pkg::EXC_ECALL_U : 6'd11;
    end else if (insn == insn_pkg::EBREAK_IDATA) begin
      trap  = 1'b1;
      cause = insn_pkg::EXC_BREAKPOINT;
    end
    if (!legal && (rnd(5) == 0)) begin
      trap  = (rnd(2) == 0);
      cause = 6'(rnd(12));
    end
    rvfi_valid   = 1'b1;
    rvfi_mode    = mode;
    rvfi_insn    = insn;
    rvfi_trap    = trap;
    rvfi_cause   = cause;
    rvfi_intr    = !legal && (rnd(12) == 0);
    rvfi_mstatus = mstatus;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #2;
    rst_n = 1'b0;
    drive_idle();
    repeat (5) @(posedge clk_i);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic run_cycles(input int cycles, input bit legal);
    repeat (cycles) begin
      @(posedge clk_i);
      #2;
      if (rnd(100) < 70) begin
        drive_retire(legal);
      end else begin
        drive_idle();
      end
    end
  endtask

  initial begin
    int n;
    clk_i        = 1'b0;
    rst_n        = 1'b0;
    drain_errors = 0;
    drive_idle();
    apply_reset();
    run_cycles(LEGAL_CYCLES, 1'b1);
    // first retirement after reset comes from U
    apply_reset();
    @(posedge clk_i);
    #2;
    drive_idle();
    rvfi_valid = 1'b1;
    rvfi_mode  = 2'b00;
    rvfi_insn  = 32'h0000_0033;
    run_cycles(RANDOM_CYCLES, 1'b0);
    @(posedge clk_i);
    #2;
    drive_idle();
    n = 0;
    while ((outstanding != 0) && (n < 10)) begin
      @(posedge clk_i);
      n++;
    end
    if (outstanding != 0) begin
      drain_errors++;
      $display("timed out waiting for the last violation reports");
    end
    repeat (2) @(posedge clk_i);
    $display("error counts: value %0d, reset wait %0d, drain wait %0d",
             value_errors, wait_errors, drain_errors);
    if ((value_errors + wait_errors + drain_errors) == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/insn_checker.sv ====
// =========================================================================
// Retired instruction privilege checks
// =========================================================================

`timescale 1ns/1ns

module insn_checker (
  input  logic [1:0]            rvfi_mode,
  input  logic [31:0]           rvfi_insn,
  input  logic                  rvfi_trap,
  input  logic [5:0]            rvfi_cause,
  input  logic [31:0]           rvfi_mstatus,
  output insn_pkg::insn_op_e    insn_op,
  output logic                  insn_fault,
  output insn_pkg::viol_code_e  insn_code
);

  logic       in_umode;
  logic       is_custom;
  logic       is_csr;
  logic [1:0] mpp;
  logic       must_illegal;
  logic       trapped_illegal;
  logic       ecall_bad;
  logic       ebreak_bad;
  logic       mstatus_bad;

  assign in_umode = (rvfi_mode == priv_pkg::MODE_U);
  assign mpp      = rvfi_mstatus[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN];

  assign is_custom =
    ((rvfi_insn & insn_pkg::CUSTOM_IMASK[0]) == insn_pkg::CUSTOM_IDATA[0]) ||
    ((rvfi_insn & insn_pkg::CUSTOM_IMASK[1]) == insn_pkg::CUSTOM_IDATA[1]);

  // csr ops are SYSTEM with a nonzero funct3
  assign is_csr = (rvfi_insn[6:0] == insn_pkg::SYSTEM_OPCODE) &&
                  (rvfi_insn[14:12] != 3'b000);

  always_comb begin
    if (rvfi_insn == insn_pkg::MRET_IDATA) begin
      insn_op = insn_pkg::OP_MRET;
    end else if (rvfi_insn == insn_pkg::WFI_IDATA) begin
      insn_op = insn_pkg::OP_WFI;
    end else if (rvfi_insn == insn_pkg::URET_IDATA) begin
      insn_op = insn_pkg::OP_URET;
    end else if (rvfi_insn == insn_pkg::ECALL_IDATA) begin
      insn_op = insn_pkg::OP_ECALL;
    end else if (rvfi_insn == insn_pkg::EBREAK_IDATA) begin
      insn_op = insn_pkg::OP_EBREAK;
    end else if (is_custom) begin
      insn_op = insn_pkg::OP_CUSTOM;
    end else if (is_csr) begin
      insn_op = insn_pkg::OP_CSR;
    end else begin
      insn_op = insn_pkg::OP_OTHER;
    end
  end

  // an instruction fault takes precedence over illegal
  assign trapped_illegal = rvfi_trap &&
    ((rvfi_cause == insn_pkg::EXC_ILLEGAL) || (rvfi_cause == insn_pkg::EXC_INSN_FAULT));

  assign must_illegal = (insn_op == insn_pkg::OP_URET) || (in_umode && (
    (insn_op == insn_pkg::OP_MRET) ||
    ((insn_op == insn_pkg::OP_WFI) && rvfi_mstatus[priv_pkg::TW_POS]) ||
    (insn_op == insn_pkg::OP_CUSTOM) ||
    ((insn_op == insn_pkg::OP_CSR) && (rvfi_insn[priv_pkg::CSR_PRIV_LSB +: 2] != 2'b00))));

  assign ecall_bad = in_umode && (insn_op == insn_pkg::OP_ECALL) && !(rvfi_trap &&
    ((rvfi_cause == insn_pkg::EXC_ECALL_U) || (rvfi_cause == insn_pkg::EXC_INSN_FAULT)));

  assign ebreak_bad = in_umode && (insn_op == insn_pkg::OP_EBREAK) && !(rvfi_trap &&
    ((rvfi_cause == insn_pkg::EXC_BREAKPOINT) || (rvfi_cause == insn_pkg::EXC_INSN_FAULT)));

  // MPP is WARL over U and M, MPRV must not stay set in U
  assign mstatus_bad = !((mpp == priv_pkg::MODE_U) || (mpp == priv_pkg::MODE_M)) ||
                       (in_umode && rvfi_mstatus[priv_pkg::MPRV_POS]);

  always_comb begin
    insn_fault = (must_illegal && !trapped_illegal) || ecall_bad || ebreak_bad || mstatus_bad;
    if (must_illegal && !trapped_illegal) begin
      insn_code = insn_pkg::VIOL_NOT_ILLEGAL;
    end else if (ecall_bad || ebreak_bad) begin
      insn_code = insn_pkg::VIOL_WRONG_CAUSE;
    end else if (mstatus_bad) begin
      insn_code = insn_pkg::VIOL_BAD_MSTATUS;
    end else begin
      insn_code = insn_pkg::VIOL_NONE;
    end
    if (insn_fault) begin
      a_fault_has_code: assert (insn_code != insn_pkg::VIOL_NONE)
        else $error("insn fault raised without a violation code");
    end
  end

endmodule

// ==== hw/insn_pkg.sv ====
// =========================================================================
// Instruction encodings, causes and violation codes
// =========================================================================

package insn_pkg;

  typedef enum logic [3:0] {
    OP_OTHER,
    OP_MRET,
    OP_WFI,
    OP_URET,
    OP_ECALL,
    OP_EBREAK,
    OP_CUSTOM,
    OP_CSR
  } insn_op_e;

  localparam logic [31:0] MRET_IDATA   = 32'h3020_0073;
  localparam logic [31:0] WFI_IDATA    = 32'h1050_0073;
  localparam logic [31:0] URET_IDATA   = 32'h0020_0073;
  localparam logic [31:0] ECALL_IDATA  = 32'h0000_0073;
  localparam logic [31:0] EBREAK_IDATA = 32'h0010_0073;

  // two custom SYSTEM patterns, index 1 first
  localparam logic [1:0][31:0] CUSTOM_IDATA = {
    32'b110011_00000000000_000_00000_1110011,
    32'b100011_00000000000_000_00000_1110011
  };
  localparam logic [1:0][31:0] CUSTOM_IMASK = {
    32'b111111_00000000000_111_00000_1111111,
    32'b111111_00000000000_111_00000_1111111
  };

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

  localparam logic [5:0] EXC_INSN_FAULT = 6'd1;
  localparam logic [5:0] EXC_ILLEGAL    = 6'd2;
  localparam logic [5:0] EXC_BREAKPOINT = 6'd3;
  localparam logic [5:0] EXC_ECALL_U    = 6'd8;

  // lower value wins when several faults hit one retirement
  typedef enum logic [2:0] {
    VIOL_NONE,
    VIOL_BAD_MODE,
    VIOL_NEXT_MODE,
    VIOL_NOT_ILLEGAL,
    VIOL_WRONG_CAUSE,
    VIOL_BAD_MSTATUS
  } viol_code_e;

endpackage

// ==== hw/mode_tracker.sv ====
// =========================================================================
// Privilege mode tracking
// =========================================================================

`timescale 1ns/1ns

module mode_tracker (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  rvfi_valid,
  input  logic [1:0]            rvfi_mode,
  input  logic                  rvfi_trap,
  input  logic                  rvfi_intr,
  input  logic [31:0]           rvfi_mstatus,
  input  insn_pkg::insn_op_e    insn_op,
  output logic                  mode_fault,
  output insn_pkg::viol_code_e  mode_code
);

  priv_pkg::priv_mode_e exp_mode;
  priv_pkg::priv_mode_e exp_mode_nxt;
  logic                 mode_ok;
  logic                 mpp_is_u;
  logic                 mret_in_m;

  assign mode_ok   = (rvfi_mode == priv_pkg::MODE_U) || (rvfi_mode == priv_pkg::MODE_M);
  assign mpp_is_u  = (rvfi_mstatus[priv_pkg::MPP_POS +: priv_pkg::MPP_LEN] == priv_pkg::MODE_U);
  assign mret_in_m = (insn_op == insn_pkg::OP_MRET) && (rvfi_mode == priv_pkg::MODE_M);

  // mode of the next retirement
  always_comb begin
    exp_mode_nxt = exp_mode;
    if (rvfi_trap) begin
      exp_mode_nxt = priv_pkg::MODE_M;
    end else if (mret_in_m) begin
      // unsupported MPP values return to M
      exp_mode_nxt = mpp_is_u ? priv_pkg::MODE_U : priv_pkg::MODE_M;
    end else if (mode_ok) begin
      exp_mode_nxt = priv_pkg::priv_mode_e'(rvfi_mode);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      exp_mode <= priv_pkg::MODE_M;
    end else if (rvfi_valid) begin
      exp_mode <= exp_mode_nxt;
    end
  end

  always_comb begin
    mode_fault = 1'b0;
    mode_code  = insn_pkg::VIOL_NONE;
    if (!mode_ok) begin
      mode_fault = 1'b1;
      mode_code  = insn_pkg::VIOL_BAD_MODE;
    end else if ((rvfi_mode != exp_mode) && !rvfi_intr) begin
      // interrupt entry excuses a mode change
      mode_fault = 1'b1;
      mode_code  = insn_pkg::VIOL_NEXT_MODE;
    end
  end

  a_exp_mode_supported: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    (exp_mode == priv_pkg::MODE_U) || (exp_mode == priv_pkg::MODE_M)
  ) else $error("expected mode left the supported set");

endmodule

// ==== hw/priv_pkg.sv ====
// =========================================================================
// Privilege modes and mstatus fields
// =========================================================================

package priv_pkg;

  // only U and M are implemented, 1 and 2 are unsupported
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_M = 2'd3
  } priv_mode_e;

  // mstatus.MPP
  localparam int MPP_POS = 11;
  localparam int MPP_LEN = 2;

  // mstatus.MPRV
  localparam int MPRV_POS = 17;

  // mstatus.TW, timeout wait
  localparam int TW_POS = 21;

  // csr addr bits [9:8] sit at insn bits [29:28]
  localparam int CSR_PRIV_LSB = 28;

endpackage

// ==== hw/umode_monitor.sv ====
// =========================================================================
// User mode privilege monitor
// =========================================================================

`timescale 1ns/1ns

module umode_monitor #(
  parameter int COUNT_W = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  rvfi_valid,
  input  logic [1:0]            rvfi_mode,
  input  logic [31:0]           rvfi_insn,
  input  logic                  rvfi_trap,
  input  logic [5:0]            rvfi_cause,
  input  logic                  rvfi_intr,
  input  logic [31:0]           rvfi_mstatus,
  output logic                  viol_valid,
  output insn_pkg::viol_code_e  viol_code,
  output logic [COUNT_W-1:0]    viol_count
);

  insn_pkg::insn_op_e   insn_op;
  logic                 insn_fault;
  insn_pkg::viol_code_e insn_code;
  logic                 mode_fault;
  insn_pkg::viol_code_e mode_code;

  insn_checker u_insn_checker (
    .rvfi_mode    (rvfi_mode),
    .rvfi_insn    (rvfi_insn),
    .rvfi_trap    (rvfi_trap),
    .rvfi_cause   (rvfi_cause),
    .rvfi_mstatus (rvfi_mstatus),
    .insn_op      (insn_op),
    .insn_fault   (insn_fault),
    .insn_code    (insn_code)
  );

  mode_tracker u_mode_tracker (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .rvfi_valid   (rvfi_valid),
    .rvfi_mode    (rvfi_mode),
    .rvfi_trap    (rvfi_trap),
    .rvfi_intr    (rvfi_intr),
    .rvfi_mstatus (rvfi_mstatus),
    .insn_op      (insn_op),
    .mode_fault   (mode_fault),
    .mode_code    (mode_code)
  );

  violation_logger #(
    .COUNT_W (COUNT_W)
  ) u_violation_logger (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .rvfi_valid (rvfi_valid),
    .mode_fault (mode_fault),
    .mode_code  (mode_code),
    .insn_fault (insn_fault),
    .insn_code  (insn_code),
    .viol_valid (viol_valid),
    .viol_code  (viol_code),
    .viol_count (viol_count)
  );

endmodule

// ==== hw/violation_logger.sv ====
// =========================================================================
// Violation report and counter
// =========================================================================

`timescale 1ns/1ns

module violation_logger #(
  parameter int COUNT_W = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  rvfi_valid,
  input  logic                  mode_fault,
  input  insn_pkg::viol_code_e  mode_code,
  input  logic                  insn_fault,
  input  insn_pkg::viol_code_e  insn_code,
  output logic                  viol_valid,
  output insn_pkg::viol_code_e  viol_code,
  output logic [COUNT_W-1:0]    viol_count
);

  logic                 report;
  insn_pkg::viol_code_e sel_code;
  logic                 count_max;

  assign report    = rvfi_valid && (mode_fault || insn_fault);
  assign count_max = (viol_count == {COUNT_W{1'b1}});

  // lower code value has priority
  always_comb begin
    sel_code = insn_code;
    if (mode_fault && (!insn_fault || (mode_code < insn_code))) begin
      sel_code = mode_code;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      viol_valid <= 1'b0;
      viol_code  <= insn_pkg::VIOL_NONE;
      viol_count <= '0;
    end else begin
      viol_valid <= report;
      viol_code  <= report ? sel_code : insn_pkg::VIOL_NONE;
      // saturate rather than wrap
      if (report && !count_max) begin
        viol_count <= viol_count + COUNT_W'(1);
      end
    end
  end

  a_valid_has_code: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    viol_valid |-> (viol_code != insn_pkg::VIOL_NONE)
  ) else $error("violation reported with code NONE");

endmodule

// ==== run.sh ====
#!/bin/sh
# build the privilege monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top \
  -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
  echo "run.sh: simulation passed"
  exit 0
fi
echo "run.sh: simulation failed, see $LOG"
exit 1

// ==== tb.f ====
hw/priv_pkg.sv
hw/insn_pkg.sv
hw/insn_checker.sv
hw/mode_tracker.sv
hw/violation_logger.sv
hw/umode_monitor.sv
dv/tb_checker.sv
dv/tb_top.sv
